/* src.f */
src/decode_pkg.sv
src/opcode_decode.sv
src/alu_funct_decode.sv
src/csr_decode.sv
src/decode_stage.sv
bench/decode_assert.sv
bench/decode_tb.sv

/* Makefile */
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert -f src.f --top-module decode_tb -o decode_sim

run: compile
	./obj_dir/decode_sim > sim.log 2>&1 || true
	cat sim.log
	grep -qx "sim passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* bench/decode_stim.txt */
# instr valid | fmt: type br width uns imm mem opa opb exres rs1 rs2 rd wb
# alu: alu mul bit | sys: csrop useimm addr ecall ebreak mret (all hex)
123452b7 1 37 2 3 0 4 0 0 2 1 00 00 05 1 0 8 0 4 0 000 0 0 0
00001317 1 17 2 3 0 4 0 3 2 1 00 00 06 1 0 8 0 4 0 000 0 0 0
008000ef 1 6f 2 3 0 5 0 0 0 0 00 00 01 3 0 8 0 4 0 000 0 0 0
000100e7 1 67 2 3 0 1 0 0 0 0 02 00 01 3 0 8 0 4 0 000 0 0 0
00419863 1 63 1 3 0 3 0 0 0 0 03 04 00 0 0 8 0 4 0 000 0 0 0
00442383 1 03 2 2 0 1 1 1 2 0 08 00 07 2 0 8 0 4 0 000 0 0 0
00054483 1 03 2 0 1 1 1 1 2 0 0a 00 09 2 0 8 0 4 0 000 0 0 0
00b61123 1 23 2 1 0 2 2 1 2 0 0c 0b 00 0 0 8 0 4 0 000 0 0 0
fff10093 1 13 2 3 0 1 0 1 2 1 02 00 01 1 1 8 0 4 0 000 0 0 0
40525193 1 13 2 3 0 1 0 1 2 1 04 00 03 1 8 8 0 4 0 000 0 0 0
60031293 1 13 2 3 0 1 0 1 2 1 06 00 05 1 0 8 1 4 0 000 0 0 0
69845393 1 13 2 3 0 1 0 1 2 1 08 00 07 1 0 8 8 4 0 000 0 0 0
403100b3 1 33 2 3 0 0 0 1 1 1 02 03 01 1 2 8 0 4 0 000 0 0 0
0262b233 1 33 2 3 0 0 0 1 1 1 05 06 04 1 0 3 0 4 0 000 0 0 0
209443b3 1 33 2 3 0 0 0 1 1 1 08 09 07 1 0 8 d 4 0 000 0 0 0
40c5f533 1 33 2 3 0 0 0 1 1 1 0b 0c 0a 1 0 8 b 4 0 000 0 0 0
300110f3 1 73 2 3 0 6 0 0 0 2 02 00 01 1 0 8 0 1 0 300 0 0 0
3412e1f3 1 73 2 3 0 6 0 0 0 2 05 00 03 1 0 8 0 2 1 341 0 0 0
00000073 1 73 2 3 0 6 0 0 0 2 00 00 00 1 0 8 0 0 0 000 1 0 0
00100073 1 73 2 3 0 6 0 0 0 2 00 00 00 1 0 8 0 0 0 001 0 1 0
30200073 1 73 2 3 0 6 0 0 0 2 00 00 00 1 0 8 0 0 0 302 0 0 1
00052007 1 07 2 3 0 0 0 0 0 0 00 00 00 0 0 8 0 4 0 000 0 0 0
00000043 1 43 2 3 0 0 0 0 0 0 00 00 00 0 0 8 0 4 0 000 0 0 0
00000013 0 00 2 3 0 0 0 0 0 0 00 00 00 0 0 8 0 4 0 000 0 0 0
00100113 1 13 2 3 0 1 0 1 2 1 00 00 02 1 1 8 0 4 0 000 0 0 0

/* bench/decode_tb.sv */
`timescale 1ns/100ps

module decode_tb import decode_pkg::*; ();

    localparam int WAIT_LIMIT = 8;

    logic         clk;
    logic         rst_n;
    logic         instr_valid;
    instr_word_u  instr;
    logic         ctrl_valid;
    decode_ctrl_t ctrl;

    int           errors;
    int           tests;
    bit           timed_out;
    decode_ctrl_t last_ctrl;

    decode_stage #(
        .HAS_MUL      (1'b1),
        .HAS_BITMANIP (1'b1)
    ) i_dut (
        .clk_i         (clk),
        .rst_n_i       (rst_n),
        .instr_valid_i (instr_valid),
        .instr_i       (instr),
        .ctrl_valid_o  (ctrl_valid),
        .ctrl_o        (ctrl)
    );

    bind decode_stage decode_assert u_decode_assert (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        #200us;
        $display("watchdog expired before the run finished");
        $display("sim failed");
        $finish;
    end

    task automatic compare_field(input string field, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t: %s is %0h, expected %0h", $time, field, got, exp);
        end
    endtask

    task automatic check_fmt(input fmt_ctrl_t got, input fmt_ctrl_t exp);
        compare_field("inst_type", 32'(got.inst_type), 32'(exp.inst_type));
        compare_field("br_cond", 32'(got.br_cond), 32'(exp.br_cond));
        compare_field("ls_width", 32'(got.ls_width), 32'(exp.ls_width));
        compare_field("mem_unsigned", 32'(got.mem_unsigned), 32'(exp.mem_unsigned));
        compare_field("imm_sel", 32'(got.imm_sel), 32'(exp.imm_sel));
        compare_field("mem_op", 32'(got.mem_op), 32'(exp.mem_op));
        compare_field("operand_a", 32'(got.operand_a), 32'(exp.operand_a));
        compare_field("operand_b", 32'(got.operand_b), 32'(exp.operand_b));
        compare_field("exec_result", 32'(got.exec_result), 32'(exp.exec_result));
        compare_field("rs1", 32'(got.rs1), 32'(exp.rs1));
        compare_field("rs2", 32'(got.rs2), 32'(exp.rs2));
        compare_field("rd", 32'(got.rd), 32'(exp.rd));
        compare_field("wb_sel", 32'(got.wb_sel), 32'(exp.wb_sel));
    endtask

    task automatic check_alu(input alu_ctrl_t got, input alu_ctrl_t exp);
        compare_field("alu_op", 32'(got.alu_op), 32'(exp.alu_op));
        compare_field("mul_op", 32'(got.mul_op), 32'(exp.mul_op));
        compare_field("bit_op", 32'(got.bit_op), 32'(exp.bit_op));
    endtask

    task automatic check_sys(input sys_ctrl_t got, input sys_ctrl_t exp);
        compare_field("csr_op", 32'(got.csr_op), 32'(exp.csr_op));
        compare_field("csr_use_imm", 32'(got.csr_use_imm), 32'(exp.csr_use_imm));
        compare_field("csr_addr", 32'(got.csr_addr), 32'(exp.csr_addr));
        compare_field("ecall", 32'(got.ecall), 32'(exp.ecall));
        compare_field("ebreak", 32'(got.ebreak), 32'(exp.ebreak));
        compare_field("mret", 32'(got.mret), 32'(exp.mret));
    endtask

    task automatic check_valid(input logic got, input logic exp);
        compare_field("ctrl_valid", 32'(got), 32'(exp));
    endtask

    task automatic check_bundle(input decode_ctrl_t exp);
        check_fmt(ctrl.fmt, exp.fmt);
        check_alu(ctrl.alu, exp.alu);
        check_sys(ctrl.sys, exp.sys);
    endtask

    // called at +2 ns; returns at +1 ns after the edge where the output shows up
    task automatic wait_for_output(output int cycles);
        cycles = 0;
        do begin
            @(posedge clk);
            #1;
            cycles++;
        end while (!ctrl_valid && cycles < WAIT_LIMIT);
    endtask

    // one idle cycle, output must hold
    task automatic idle_cycle(input instr_word_u word);
        instr_valid = 1'b0;
        instr = word;
        @(posedge clk);
        #1;
        check_valid(ctrl_valid, 1'b0);
        check_bundle(last_ctrl);
        #1;
    endtask

    function automatic decode_ctrl_t unpack_expected(input logic [31:0] f [24]);
        decode_ctrl_t e;
        e.fmt.inst_type = rv32_opcode_e'(f[2][6:0]);
        e.fmt.br_cond = br_cond_e'(f[3][2:0]);
        e.fmt.ls_width = ls_width_e'(f[4][1:0]);
        e.fmt.mem_unsigned = f[5][0];
        e.fmt.imm_sel = imm_sel_e'(f[6][2:0]);
        e.fmt.mem_op = mem_op_e'(f[7][1:0]);
        e.fmt.operand_a = operand_e'(f[8][1:0]);
        e.fmt.operand_b = operand_e'(f[9][1:0]);
        e.fmt.exec_result = exec_result_e'(f[10][1:0]);
        e.fmt.rs1 = f[11][4:0];
        e.fmt.rs2 = f[12][4:0];
        e.fmt.rd = f[13][4:0];
        e.fmt.wb_sel = wb_sel_e'(f[14][1:0]);
        e.alu.alu_op = alu_op_e'(f[15][3:0]);
        e.alu.mul_op = mul_op_e'(f[16][3:0]);
        e.alu.bit_op = bit_op_e'(f[17][4:0]);
        e.sys.csr_op = csr_op_e'(f[18][2:0]);
        e.sys.csr_use_imm = f[19][0];
        e.sys.csr_addr = f[20][11:0];
        e.sys.ecall = f[21][0];
        e.sys.ebreak = f[22][0];
        e.sys.mret = f[23][0];
        return e;
    endfunction

    initial begin
        int           fd;
        int           code;
        int           cycles;
        int           gap;
        int           errs_before;
        string        line;
        logic [31:0]  f [24];
        decode_ctrl_t exp;

        void'($urandom(35237));
        errors = 0;
        tests = 0;
        timed_out = 1'b0;
        rst_n = 1'b0;
        instr_valid = 1'b0;
        instr = '0;

        repeat (5) @(posedge clk);
        #1;
        check_valid(ctrl_valid, 1'b0);   // still in reset
        check_bundle(DECODE_DEFAULT);
        #1;
        rst_n = 1'b1;
        @(posedge clk);
        #1;
        check_valid(ctrl_valid, 1'b0);
        check_bundle(DECODE_DEFAULT);
        #1;
        tests++;
        $display("test %0d reset: %s", tests, (errors == 0) ? "ok" : "FAIL");
        last_ctrl = DECODE_DEFAULT;

        fd = $fopen("bench/decode_stim.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file bench/decode_stim.txt");
            timed_out = 1'b1;
        end else begin
            while (!$feof(fd) && !timed_out) begin
                code = $fgets(line, fd);
                if (code == 0 || line.len() < 8 || line[0] == 8'h23) continue;
                code = $sscanf(line,
                    "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11],
                    f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19], f[20], f[21],
                    f[22], f[23]);
                if (code != 24) begin
                    $display("malformed stimulus line: %s", line);
                    errors++;
                    continue;
                end
                tests++;
                errs_before = errors;
                if (f[1][0]) begin
                    exp = unpack_expected(f);
                    instr = instr_word_u'(f[0]);
                    instr_valid = 1'b1;
                    wait_for_output(cycles);
                    if (!ctrl_valid) begin
                        $display("decoded output never became valid for %h", f[0]);
                        timed_out = 1'b1;
                    end else begin
                        if (cycles != 1) begin
                            errors++;
                            $display("[ERROR] %0t: latency %0d cycles, expected 1",
                                     $time, cycles);
                        end
                        check_bundle(exp);
                        last_ctrl = exp;
                    end
                    #1;
                    instr_valid = 1'b0;
                end else begin
                    idle_cycle(instr_word_u'(f[0]));
                end
                $display("test %0d instr %h: %s", tests, f[0],
                         (errors == errs_before && !timed_out) ? "ok" : "FAIL");
                if (tests % 4 == 0) begin
                    gap = $urandom % 3;  // some vectors stay back to back
                    repeat (gap) idle_cycle('0);
                end
            end
            $fclose(fd);
        end

        if (i_dut.u_decode_assert.fail_count != 0) begin
            $display("bound assertions failed %0d times", i_dut.u_decode_assert.fail_count);
            errors += i_dut.u_decode_assert.fail_count;
        end

        $display("tests %0d, errors %0d", tests, errors);
        if (errors == 0 && !timed_out) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* bench/decode_assert.sv */
`timescale 1ns/100ps

module decode_assert import decode_pkg::*; (
    input logic         clk_i,
    input logic         rst_n_i,
    input logic         instr_valid_i,
    input logic         ctrl_valid_o,
    input decode_ctrl_t ctrl_o
);

    int unsigned fail_count = 0;

    // output valid is the input valid delayed by one cycle
    a_valid_follows: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        ctrl_valid_o == $past(instr_valid_i))
        else begin
            fail_count++;
            $error("ctrl_valid_o does not follow instr_valid_i");
        end

    a_one_env_flag: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $onehot0({ctrl_o.sys.ecall, ctrl_o.sys.ebreak, ctrl_o.sys.mret}))
        else begin
            fail_count++;
            $error("more than one of ecall, ebreak and mret is high");
        end

    a_store_no_rd: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (ctrl_o.fmt.mem_op == WRITE) |-> (ctrl_o.fmt.rd == NO_REG))
        else begin
            fail_count++;
            $error("store decoded with a destination register");
        end

endmodule

/* src/decode_stage.sv */
`timescale 1ns/100ps

module decode_stage import decode_pkg::*; #(
    parameter bit HAS_MUL      = 1'b1,
    parameter bit HAS_BITMANIP = 1'b1
) (
    input  logic         clk_i,
    input  logic         rst_n_i,
    input  logic         instr_valid_i,
    input  instr_word_u  instr_i,
    output logic         ctrl_valid_o,
    output decode_ctrl_t ctrl_o
);

    fmt_ctrl_t    fmt;
    alu_ctrl_t    alu;
    sys_ctrl_t    sys;
    funct_sel_e   funct_sel;
    decode_ctrl_t ctrl_d;

    opcode_decode u_opcode_decode (
        .instr_i     (instr_i),
        .fmt_o       (fmt),
        .funct_sel_o (funct_sel)
    );

    alu_funct_decode #(
        .HAS_MUL      (HAS_MUL),
        .HAS_BITMANIP (HAS_BITMANIP)
    ) u_alu_funct_decode (
        .instr_i     (instr_i),
        .funct_sel_i (funct_sel),
        .alu_o       (alu)
    );

    csr_decode u_csr_decode (
        .instr_i     (instr_i),
        .funct_sel_i (funct_sel),
        .sys_o       (sys)
    );

    assign ctrl_d = '{fmt: fmt, alu: alu, sys: sys};

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ctrl_valid_o <= 1'b0;
            ctrl_o <= DECODE_DEFAULT;
        end else begin
            ctrl_valid_o <= instr_valid_i;
            if (instr_valid_i) begin
                ctrl_o <= ctrl_d;   // holds across idle cycles
            end
        end
    end

endmodule

/* src/csr_decode.sv */
`timescale 1ns/100ps

module csr_decode import decode_pkg::*; (
    input  instr_word_u instr_i,
    input  funct_sel_e  funct_sel_i,
    output sys_ctrl_t   sys_o
);

    csr_op_e   csr_op;
    csr_addr_t csr_addr;
    logic      use_imm;

    always_comb begin
        csr_op = NO_CSR_OP;
        csr_addr = NO_CSR_ADDR;
        use_imm = 1'b0;
        if (funct_sel_i == FS_SYSTEM) begin
            csr_op = csr_op_e'({1'b0, instr_i.i.funct3[1:0]});  // 00 is priv/env
            use_imm = instr_i.i.funct3[2];
            csr_addr = instr_i.i.imm_11_0;
        end
    end

    assign sys_o = '{
        csr_op:      csr_op,
        csr_use_imm: use_imm,
        csr_addr:    csr_addr,
        ecall:       (csr_op == SYSTEM) && (csr_addr == 12'h000),
        ebreak:      (csr_op == SYSTEM) && (csr_addr == 12'h001),
        mret:        (csr_op == SYSTEM) && (csr_addr == 12'h302)
    };

endmodule

/* src/alu_funct_decode.sv */
`timescale 1ns/100ps

module alu_funct_decode import decode_pkg::*; #(
    parameter bit HAS_MUL      = 1'b1,
    parameter bit HAS_BITMANIP = 1'b1
) (
    input  instr_word_u instr_i,
    input  funct_sel_e  funct_sel_i,
    output alu_ctrl_t   alu_o
);

    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [4:0] funct5;
    alu_op_e    alu_op;
    mul_op_e    mul_op;
    bit_op_e    bit_op;

    assign funct3 = instr_i.r.funct3;
    assign funct7 = instr_i.r.funct7;
    assign funct5 = instr_i.r.rs2;  // shamt / unary selector

    always_comb begin
        alu_op = NO_ALU_OP;
        mul_op = NO_MUL_OP;
        bit_op = NO_BIT_OP;

        case (funct_sel_i)
            FS_OP_IMM: begin
                case (funct3)
                    3'b000: alu_op = ADD;
                    3'b001: begin
                        if (funct7 == 7'b0000000) begin
                            alu_op = SLL;
                        end else if (funct7 == 7'b0110000) begin
                            case (funct5)
                                5'b00000: bit_op = CLZ;
                                5'b00001: bit_op = CTZ;
                                5'b00010: bit_op = CPOP;
                                5'b00100: bit_op = SEXTB;
                                5'b00101: bit_op = SEXTH;
                                default:  ;
                            endcase
                        end
                    end
                    3'b010: alu_op = SLT;
                    3'b011: alu_op = SLTU;
                    3'b100: alu_op = XOR;
                    3'b101: begin
                        casez ({funct7, funct5})
                            {7'b0000000, 5'b?????}: alu_op = SRL;
                            {7'b0100000, 5'b?????}: alu_op = SRA;
                            {7'b0110000, 5'b?????}: bit_op = RORI;
                            {7'b0010100, 5'b00111}: bit_op = ORCB;
                            {7'b0110100, 5'b11000}: bit_op = REV8;
                            default:                ;
                        endcase
                    end
                    3'b110: alu_op = OR;
                    default: alu_op = AND;
                endcase
            end
            FS_OP_REG: begin
                case (funct7)
                    7'b0000000: begin
                        case (funct3)
                            3'b000: alu_op = ADD;
                            3'b001: alu_op = SLL;
                            3'b010: alu_op = SLT;
                            3'b011: alu_op = SLTU;
                            3'b100: alu_op = XOR;
                            3'b101: alu_op = SRL;
                            3'b110: alu_op = OR;
                            default: alu_op = AND;
                        endcase
                    end
                    7'b0000001: mul_op = mul_op_e'({1'b0, funct3});
                    7'b0100000: begin
                        case (funct3)
                            3'b000: alu_op = SUB;
                            3'b100: bit_op = XNOR;
                            3'b101: alu_op = SRA;
                            3'b110: bit_op = ORN;
                            3'b111: bit_op = ANDN;
                            default: ;
                        endcase
                    end
                    7'b0010000: begin
                        case (funct3)
                            3'b010: bit_op = SH1ADD;
                            3'b100: bit_op = SH2ADD;
                            3'b110: bit_op = SH3ADD;
                            default: ;
                        endcase
                    end
                    7'b0000101: begin
                        case (funct3)
                            3'b100: bit_op = MIN;
                            3'b101: bit_op = MINU;
                            3'b110: bit_op = MAX;
                            3'b111: bit_op = MAXU;
                            default: ;
                        endcase
                    end
                    7'b0110000: begin
                        if (funct3 == 3'b001) begin
                            bit_op = ROL;
                        end else if (funct3 == 3'b101) begin
                            bit_op = ROR;
                        end
                    end
                    7'b0000100: if (funct3 == 3'b100) bit_op = ZEXTH;  // rs2 must be x0
                    default: ;
                endcase
            end
            default: ;
        endcase
    end

    // absent extensions decode as nothing
    assign alu_o = '{
        alu_op: alu_op,
        mul_op: HAS_MUL ? mul_op : NO_MUL_OP,
        bit_op: HAS_BITMANIP ? bit_op : NO_BIT_OP
    };

endmodule

/* src/opcode_decode.sv */
`timescale 1ns/100ps

module opcode_decode import decode_pkg::*; (
    input  instr_word_u instr_i,
    output fmt_ctrl_t   fmt_o,
    output funct_sel_e  funct_sel_o
);

    rv32_opcode_e opcode;

    assign opcode = rv32_opcode_e'(instr_i.r.opcode);

    always_comb begin
        fmt_o = FMT_DEFAULT;
        funct_sel_o = FS_NONE;
        fmt_o.inst_type = opcode;   // raw value, also for unknown ones

        case (opcode)
            LUI: begin
                fmt_o.imm_sel = U_IMM;
                fmt_o.operand_b = IMM;
                fmt_o.exec_result = ALU_RES;
                fmt_o.rd = instr_i.u.rd;
                fmt_o.wb_sel = EXEC;
            end
            AUIPC: begin
                fmt_o.imm_sel = U_IMM;
                fmt_o.operand_a = PC;
                fmt_o.operand_b = IMM;
                fmt_o.exec_result = ALU_RES;
                fmt_o.rd = instr_i.u.rd;
                fmt_o.wb_sel = EXEC;
            end
            JUMP: begin
                fmt_o.imm_sel = J_IMM;
                fmt_o.rd = instr_i.j.rd;
                fmt_o.wb_sel = PC_WB;   // link address
            end
            JUMP_R: begin
                fmt_o.imm_sel = I_IMM;
                fmt_o.rs1 = instr_i.i.rs1;
                fmt_o.rd = instr_i.i.rd;
                fmt_o.wb_sel = PC_WB;
            end
            BRANCH: begin
                fmt_o.br_cond = br_cond_e'(instr_i.b.funct3);
                fmt_o.imm_sel = B_IMM;
                fmt_o.rs1 = instr_i.b.rs1;
                fmt_o.rs2 = instr_i.b.rs2;
            end
            LOAD: begin
                fmt_o.ls_width = ls_width_e'(instr_i.i.funct3[1:0]);
                fmt_o.mem_unsigned = instr_i.i.funct3[2];   // lbu, lhu
                fmt_o.imm_sel = I_IMM;
                fmt_o.mem_op = READ;
                fmt_o.operand_a = REGISTER;
                fmt_o.operand_b = IMM;
                fmt_o.rs1 = instr_i.i.rs1;
                fmt_o.rd = instr_i.i.rd;
                fmt_o.wb_sel = MEMORY;
            end
            STORE: begin
                fmt_o.ls_width = ls_width_e'(instr_i.s.funct3[1:0]);
                fmt_o.imm_sel = S_IMM;
                fmt_o.mem_op = WRITE;
                fmt_o.operand_a = REGISTER;
                fmt_o.operand_b = IMM;
                fmt_o.rs1 = instr_i.s.rs1;
                fmt_o.rs2 = instr_i.s.rs2;
            end
            OP_I: begin
                funct_sel_o = FS_OP_IMM;
                fmt_o.imm_sel = I_IMM;
                fmt_o.operand_a = REGISTER;
                fmt_o.operand_b = IMM;
                fmt_o.exec_result = ALU_RES;
                fmt_o.rs1 = instr_i.i.rs1;
                fmt_o.rd = instr_i.i.rd;
                fmt_o.wb_sel = EXEC;
            end
            OP_R: begin
                funct_sel_o = FS_OP_REG;
                fmt_o.operand_a = REGISTER;
                fmt_o.operand_b = REGISTER;
                fmt_o.exec_result = ALU_RES;
                fmt_o.rs1 = instr_i.r.rs1;
                fmt_o.rs2 = instr_i.r.rs2;
                fmt_o.rd = instr_i.r.rd;
                fmt_o.wb_sel = EXEC;
            end
            CSR: begin
                funct_sel_o = FS_SYSTEM;
                fmt_o.imm_sel = CSR_IMM;    // zimm sits in the rs1 field
                fmt_o.exec_result = CSR_RES;
                fmt_o.rs1 = instr_i.i.rs1;
                fmt_o.rd = instr_i.i.rd;
                fmt_o.wb_sel = EXEC;
            end
            default: ;  // FP and unknown opcodes stay at default
        endcase
    end

endmodule

/* src/decode_pkg.sv */
package decode_pkg;

    typedef enum logic [6:0] {
        NO_OPCODE = 7'b0000000,
        LOAD      = 7'b0000011,
        OP_I      = 7'b0010011,
        AUIPC     = 7'b0010111,
        STORE     = 7'b0100011,
        OP_R      = 7'b0110011,
        LUI       = 7'b0110111,
        BRANCH    = 7'b1100011,
        JUMP_R    = 7'b1100111,
        JUMP      = 7'b1101111,
        CSR       = 7'b1110011   // SYSTEM major opcode
    } rv32_opcode_e;

    typedef logic [4:0]  reg_addr_t;
    typedef logic [11:0] csr_addr_t;

    localparam reg_addr_t NO_REG      = 5'd0;   // x0
    localparam csr_addr_t NO_CSR_ADDR = 12'd0;

    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } instr_word_u;

    typedef enum logic [1:0] {FS_NONE, FS_OP_REG, FS_OP_IMM, FS_SYSTEM} funct_sel_e;

    typedef enum logic [2:0] {
        BEQ = 3'b000, BNE = 3'b001, NO_CONDITION = 3'b010,
        BLT = 3'b100, BGE = 3'b101, BLTU = 3'b110, BGEU = 3'b111
    } br_cond_e;

    typedef enum logic [1:0] {BYTE, HALF, WORD, NO_WIDTH} ls_width_e;
    typedef enum logic [2:0] {NO_IMM, I_IMM, S_IMM, B_IMM, U_IMM, J_IMM, CSR_IMM} imm_sel_e;
    typedef enum logic [1:0] {NO_MEM_OP, READ, WRITE} mem_op_e;
    typedef enum logic [1:0] {NO_OPERAND, REGISTER, IMM, PC} operand_e;
    typedef enum logic [1:0] {NO_EX_RES, ALU_RES, CSR_RES} exec_result_e;
    typedef enum logic [1:0] {NO_WB, EXEC, MEMORY, PC_WB} wb_sel_e;

    typedef enum logic [3:0] {
        NO_ALU_OP, ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND, PASS
    } alu_op_e;

    // low three bits follow funct3 of the M extension
    typedef enum logic [3:0] {
        MUL, MULH, MULHSU, MULHU, DIV, DIVU, REM, REMU, NO_MUL_OP
    } mul_op_e;

    typedef enum logic [4:0] {
        NO_BIT_OP, CLZ, CTZ, CPOP, SEXTB, SEXTH, RORI, ORCB, REV8, XNOR, ORN,
        ANDN, SH1ADD, SH2ADD, SH3ADD, MIN, MINU, MAX, MAXU, ROL, ROR, ZEXTH
    } bit_op_e;

    typedef enum logic [2:0] {SYSTEM, CSRRW, CSRRS, CSRRC, NO_CSR_OP} csr_op_e;

    typedef struct packed {
        rv32_opcode_e inst_type;
        br_cond_e     br_cond;
        ls_width_e    ls_width;
        logic         mem_unsigned;
        imm_sel_e     imm_sel;
        mem_op_e      mem_op;
        operand_e     operand_a;
        operand_e     operand_b;
        exec_result_e exec_result;
        reg_addr_t    rs1;
        reg_addr_t    rs2;
        reg_addr_t    rd;
        wb_sel_e      wb_sel;
    } fmt_ctrl_t;

    typedef struct packed {
        alu_op_e alu_op;
        mul_op_e mul_op;
        bit_op_e bit_op;
    } alu_ctrl_t;

    typedef struct packed {
        csr_op_e   csr_op;
        logic      csr_use_imm;
        csr_addr_t csr_addr;
        logic      ecall;
        logic      ebreak;
        logic      mret;
    } sys_ctrl_t;

    typedef struct packed {
        fmt_ctrl_t fmt;
        alu_ctrl_t alu;
        sys_ctrl_t sys;
    } decode_ctrl_t;

    localparam fmt_ctrl_t FMT_DEFAULT = '{
        inst_type: NO_OPCODE, br_cond: NO_CONDITION, ls_width: NO_WIDTH,
        mem_unsigned: 1'b0, imm_sel: NO_IMM, mem_op: NO_MEM_OP,
        operand_a: NO_OPERAND, operand_b: NO_OPERAND, exec_result: NO_EX_RES,
        rs1: NO_REG, rs2: NO_REG, rd: NO_REG, wb_sel: NO_WB
    };

    localparam alu_ctrl_t ALU_DEFAULT = '{
        alu_op: NO_ALU_OP, mul_op: NO_MUL_OP, bit_op: NO_BIT_OP
    };

    localparam sys_ctrl_t SYS_DEFAULT = '{
        csr_op: NO_CSR_OP, csr_use_imm: 1'b0, csr_addr: NO_CSR_ADDR,
        ecall: 1'b0, ebreak: 1'b0, mret: 1'b0
    };

    localparam decode_ctrl_t DECODE_DEFAULT = '{
        fmt: FMT_DEFAULT, alu: ALU_DEFAULT, sys: SYS_DEFAULT
    };

endpackage
